// ==== source/audio_pkg.sv ====
// Audio sample, frame and coefficient types shared by the capture path,
// the RAMs and the multiply-accumulate sequencer.
// Modules take what they need with a wildcard import in their header.
`default_nettype none

package audio_pkg;

    localparam int SAMPLE_W = 16;
    localparam int FRAME_W  = 8;
    localparam int CHAN_W   = 2;
    localparam int ACC_W    = 40;
    localparam int COEF_W   = 32;

    // Taps per output channel
    localparam int TAPS  = 8;
    localparam int TAP_W = $clog2(TAPS);

    // Coefficient word fields, low bit of each
    localparam int COEF_GAIN_LSB  = 0;
    localparam int COEF_DELAY_LSB = 16;
    localparam int COEF_CHAN_LSB  = 24;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [FRAME_W-1:0]         frame_t;
    typedef logic [CHAN_W-1:0]          chan_t;

    // Channel sits above frame
    typedef logic [CHAN_W+FRAME_W-1:0]  audio_addr_t;

    typedef logic [COEF_W-1:0]          coef_t;

    // Output select bit above tap number
    typedef logic [TAP_W:0]             coef_addr_t;

    typedef logic signed [ACC_W-1:0]    acc_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_mac,
        st_store
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/bus_pkg.sv ====
// Register map of the audio peripheral on the iomem bus.
// Offsets are relative to the base address, taken from address bits 11:0.
`default_nettype none

package bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [11:0] bus_ofs_t;

    localparam bus_ofs_t OFS_COEF   = 12'h000;
    localparam bus_ofs_t OFS_RESULT = 12'h100;
    localparam bus_ofs_t OFS_STATUS = 12'h200;
    localparam bus_ofs_t OFS_RUN    = 12'h300;
    localparam bus_ofs_t OFS_AUDIO  = 12'h400;

    // Status word read bits
    localparam int ST_DONE  = 0;
    localparam int ST_ERROR = 1;
    localparam int ST_BUSY  = 2;

    // Control word write bits
    localparam int CTL_HOST      = 0;
    localparam int CTL_FRAME_LSB = 1;

    // Audio writes: word index is the frame, channel rides in the data word
    localparam int AUDIO_CHAN_LSB = 16;

endpackage

`default_nettype wire

// ==== source/i2s_if.sv ====
// Shared I2S bit timing. The clock generator drives it,
// the receivers and the transmitter follow it.
`timescale 1ns/10ps
`default_nettype none

interface i2s_if;

    logic       en;
    logic [5:0] bit_posn;
    logic       ws;
    logic       frame_start;

    modport source (output en, output bit_posn, output ws, output frame_start);

    modport shifter (input en, input bit_posn, input ws, input frame_start);

endinterface

`default_nettype wire

// ==== source/i2s_clock.sv ====
// I2S bit clock generator. Divides ck by DIVIDER into bit enables and
// counts 64 positions per frame; sck and ws are bits of that position.
// frame_start marks the enable on which the position wraps to 0.
`timescale 1ns/10ps
`default_nettype none

module i2s_clock #(
    parameter int DIVIDER = 6
) (
    input  logic   ck,
    input  logic   rst_n,
    i2s_if.source  i2s,
    output logic   sck
);

    localparam int                DIV_W    = $clog2(DIVIDER);
    localparam logic [DIV_W-1:0]  DIV_LAST = DIV_W'(DIVIDER - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       posn;
    logic             en;

    assign en = (div_cnt == DIV_LAST);

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            posn    <= '0;
        end else begin
            if (en) begin
                div_cnt <= '0;
                posn    <= posn + 6'd1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign i2s.en          = en;
    assign i2s.bit_posn    = posn;
    assign i2s.ws          = posn[5];
    assign i2s.frame_start = en && (posn == 6'd63);

    assign sck = posn[0];

endmodule

`default_nettype wire

// ==== source/i2s_rx.sv ====
// I2S receiver for one data line. Samples sd as sck rises and hands out
// the left and right words, MSB first and left-justified, once each
// half-frame has been shifted in.
`timescale 1ns/10ps
`default_nettype none

module i2s_rx
    import audio_pkg::*;
(
    input  logic    ck,
    input  logic    rst_n,
    i2s_if.shifter  i2s,
    input  logic    sd,
    output sample_t left,
    output sample_t right
);

    sample_t shift;

    // Even position means sck goes high on this enable
    always_ff @(posedge ck) begin
        if (i2s.en && !i2s.bit_posn[0]) begin
            shift <= {shift[SAMPLE_W-2:0], sd};
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else if (i2s.en && (i2s.bit_posn[4:0] == 5'd31)) begin
            // Last slot of the half-frame
            if (i2s.ws) begin
                right <= shift;
            end else begin
                left <= shift;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/i2s_tx.sv ====
// I2S transmitter. Loads left and right at frame start and shifts them
// out MSB first, changing sd on each falling edge of sck.
// The word shifts in zeros behind it, so sd idles low.
`timescale 1ns/10ps
`default_nettype none

module i2s_tx
    import audio_pkg::*;
(
    input  logic    ck,
    input  logic    rst_n,
    i2s_if.shifter  i2s,
    input  sample_t left,
    input  sample_t right,
    output logic    sd
);

    logic [2*SAMPLE_W-1:0] shift;

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            shift <= '0;
        end else if (i2s.frame_start) begin
            shift <= {left, right};
        end else if (i2s.en && i2s.bit_posn[0]) begin
            // sck falls on this enable
            shift <= {shift[2*SAMPLE_W-2:0], 1'b0};
        end
    end

    assign sd = shift[2*SAMPLE_W-1];

endmodule

`default_nettype wire

// ==== source/dpram.sv ====
// Simple dual port RAM, one write port and one registered read port.
// Read data follows the address by one clock.
// Holds the coefficient program and the captured audio.
`timescale 1ns/10ps
`default_nettype none

module dpram #(
    parameter int BITS  = 16,
    parameter int DEPTH = 256
) (
    input  logic                     ck,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [BITS-1:0]          wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [BITS-1:0]          rdata
);

    logic [BITS-1:0] mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== source/sequencer.sv ====
// Multiply-accumulate sequencer. On start it runs the fixed program in the
// coefficient RAM: for each output and each tap it reads a delayed sample
// of one channel, scales it by a Q1.15 gain and sums. Each sum is shifted
// down by 15, saturated and stored as left, then right.
// Roughly three clocks per tap; done rises once right is stored.
`timescale 1ns/10ps
`default_nettype none

module sequencer
    import audio_pkg::*;
(
    input  logic        ck,
    input  logic        rst_n,
    input  logic        start,
    input  frame_t      frame,
    output coef_addr_t  coef_addr,
    input  coef_t       coef_data,
    output audio_addr_t audio_addr,
    input  sample_t     audio_data,
    output sample_t     left,
    output sample_t     right,
    output logic        done,
    output logic        busy,
    output logic        error,
    input  logic        error_clr
);

    localparam logic [TAP_W-1:0] TAP_LAST = TAP_W'(TAPS - 1);
    localparam acc_t             SAT_MAX  = 40'sd32767;
    localparam acc_t             SAT_MIN  = -40'sd32768;

    seq_state_t         state;
    frame_t             frame_r;
    logic               out_sel;
    logic [TAP_W-1:0]   tap;
    logic               fetch_wait;
    acc_t               acc;

    chan_t              tap_chan;
    frame_t             tap_delay;
    frame_t             tap_frame;
    sample_t            gain;
    logic signed [31:0] product;
    acc_t               scaled;
    sample_t            sat;

    assign coef_addr = {out_sel, tap};

    // Fields of the coefficient being worked on
    assign tap_chan  = coef_data[COEF_CHAN_LSB +: CHAN_W];
    assign tap_delay = coef_data[COEF_DELAY_LSB +: FRAME_W];
    assign gain      = coef_data[COEF_GAIN_LSB +: SAMPLE_W];

    // Delay wraps round the 256 frame ring
    assign tap_frame  = frame_r - tap_delay;
    assign audio_addr = {tap_chan, tap_frame};

    assign product = audio_data * gain;

    assign scaled = acc >>> 15;

    always_comb begin
        if (scaled > SAT_MAX) begin
            sat = 16'h7fff;
        end else if (scaled < SAT_MIN) begin
            sat = 16'h8000;
        end else begin
            sat = scaled[SAMPLE_W-1:0];
        end
    end

    assign busy = (state != st_idle);

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            frame_r    <= '0;
            out_sel    <= 1'b0;
            tap        <= '0;
            fetch_wait <= 1'b0;
            acc        <= '0;
            left       <= '0;
            right      <= '0;
            done       <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        frame_r    <= frame;
                        out_sel    <= 1'b0;
                        tap        <= '0;
                        acc        <= '0;
                        fetch_wait <= 1'b1;
                        done       <= 1'b0;
                        state      <= st_fetch;
                    end
                end
                st_fetch: begin
                    // First clock presents the tap address, second has the coefficient
                    if (fetch_wait) begin
                        fetch_wait <= 1'b0;
                    end else begin
                        state <= st_mac;
                    end
                end
                st_mac: begin
                    acc <= acc + acc_t'(product);
                    if (tap == TAP_LAST) begin
                        state <= st_store;
                    end else begin
                        tap        <= tap + 1'b1;
                        fetch_wait <= 1'b1;
                        state      <= st_fetch;
                    end
                end
                st_store: begin
                    if (out_sel) begin
                        right <= sat;
                        done  <= 1'b1;
                        state <= st_idle;
                    end else begin
                        left       <= sat;
                        out_sel    <= 1'b1;
                        tap        <= '0;
                        acc        <= '0;
                        fetch_wait <= 1'b1;
                        state      <= st_fetch;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Sticky until the host writes control
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            error <= 1'b0;
        end else if (error_clr) begin
            error <= 1'b0;
        end else if (start && busy) begin
            error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/audio_engine.sv ====
// Audio peripheral top level for the iomem bus.
// Captures four I2S channels per frame into the audio RAM, runs the
// sequencer on each new frame and plays left/right out on sd_out.
// In host mode capture stops; the host fills the audio RAM, picks a frame
// and starts the sequencer with a RUN write. Each access is acked with a
// single ready pulse one clock after valid.
`timescale 1ns/10ps
`default_nettype none

module audio_engine
    import audio_pkg::*, bus_pkg::*;
#(
    parameter bus_addr_t BASE_ADDR = 32'h0000_6000,
    parameter int        DIVIDER   = 6
) (
    input  logic      ck,
    input  logic      rst_n,
    input  logic      iomem_valid,
    output logic      iomem_ready,
    input  logic [3:0] iomem_wstrb,
    input  bus_addr_t iomem_addr,
    input  bus_data_t iomem_wdata,
    output bus_data_t iomem_rdata,
    output logic      sck,
    output logic      ws,
    output logic      sd_out,
    input  logic      sd_in0,
    input  logic      sd_in1
);

    bus_ofs_t    ofs;
    logic        hit, access, wr, rd;
    logic        coef_sel, result_sel, status_sel, run_sel, audio_sel;
    logic        ctl_wr, run_req;
    bus_data_t   rd_value;

    logic        host_mode;
    frame_t      host_frame;
    frame_t      frame_counter;
    logic        writing, cap_start;
    chan_t       cap_chan;
    sample_t     mic [1 << CHAN_W];

    logic        audio_we;
    audio_addr_t audio_waddr, audio_raddr;
    sample_t     audio_wdata, audio_rdata;
    coef_addr_t  coef_raddr;
    coef_t       coef_rdata;
    sample_t     res_left, res_right;
    logic        done, busy, error;

    i2s_if i2s ();

    i2s_clock #(.DIVIDER(DIVIDER)) u_clock (.ck(ck), .rst_n(rst_n), .i2s(i2s), .sck(sck));

    assign ws = i2s.ws;

    i2s_rx u_rx0 (.ck(ck), .rst_n(rst_n), .i2s(i2s), .sd(sd_in0), .left(mic[0]), .right(mic[1]));
    i2s_rx u_rx1 (.ck(ck), .rst_n(rst_n), .i2s(i2s), .sd(sd_in1), .left(mic[2]), .right(mic[3]));

    i2s_tx u_tx (.ck(ck), .rst_n(rst_n), .i2s(i2s), .left(res_left), .right(res_right),
                 .sd(sd_out));

    // Bus decode
    assign ofs        = iomem_addr[11:0];
    assign hit        = (iomem_addr[31:12] == BASE_ADDR[31:12]);
    assign access     = iomem_valid && !iomem_ready;
    assign wr         = access && (iomem_wstrb != 4'h0);
    assign rd         = access && (iomem_wstrb == 4'h0);
    assign coef_sel   = hit && (ofs[11:6] == OFS_COEF[11:6]);
    assign result_sel = hit && (ofs[11:3] == OFS_RESULT[11:3]);
    assign status_sel = hit && (ofs[11:3] == OFS_STATUS[11:3]);
    assign run_sel    = hit && (ofs[11:2] == OFS_RUN[11:2]);
    assign audio_sel  = hit && (ofs[11:10] == OFS_AUDIO[11:10]);

    assign ctl_wr  = wr && status_sel && !ofs[2];
    assign run_req = wr && run_sel;

    always_comb begin
        rd_value = '0;
        if (result_sel) begin
            rd_value[SAMPLE_W-1:0] = ofs[2] ? res_right : res_left;
        end else if (status_sel) begin
            if (ofs[2]) begin
                rd_value[FRAME_W-1:0] = frame_counter;
            end else begin
                rd_value[ST_DONE]  = done;
                rd_value[ST_ERROR] = error;
                rd_value[ST_BUSY]  = busy;
            end
        end
    end

    // Fixed one clock wait, rdata only valid alongside ready
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            iomem_ready <= 1'b0;
            iomem_rdata <= '0;
        end else begin
            iomem_ready <= access;
            iomem_rdata <= rd ? rd_value : '0;
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            host_mode  <= 1'b0;
            host_frame <= '0;
        end else if (ctl_wr) begin
            host_mode  <= iomem_wdata[CTL_HOST];
            host_frame <= iomem_wdata[CTL_FRAME_LSB +: FRAME_W];
        end
    end

    // Capture writer, one channel per clock after each frame start
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            writing       <= 1'b0;
            cap_start     <= 1'b0;
            cap_chan      <= '0;
            frame_counter <= '0;
        end else begin
            cap_start <= 1'b0;
            if (host_mode) begin
                writing <= 1'b0;
            end else if (i2s.frame_start) begin
                writing       <= 1'b1;
                cap_chan      <= '0;
                frame_counter <= frame_counter + 1'b1;
            end else if (writing) begin
                cap_chan <= cap_chan + 1'b1;
                if (cap_chan == chan_t'((1 << CHAN_W) - 1)) begin
                    writing   <= 1'b0;
                    cap_start <= 1'b1;
                end
            end
        end
    end

    // Host owns the audio write port in host mode
    always_comb begin
        if (host_mode) begin
            audio_we    = wr && audio_sel;
            audio_waddr = {iomem_wdata[AUDIO_CHAN_LSB +: CHAN_W], ofs[9:2]};
            audio_wdata = iomem_wdata[SAMPLE_W-1:0];
        end else begin
            audio_we    = writing;
            audio_waddr = {cap_chan, frame_counter};
            audio_wdata = mic[cap_chan];
        end
    end

    dpram #(.BITS(COEF_W), .DEPTH(16)) u_coef_ram (
        .ck(ck), .we(wr && coef_sel), .waddr(ofs[5:2]), .wdata(iomem_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    dpram #(.BITS(SAMPLE_W), .DEPTH(1024)) u_audio_ram (
        .ck(ck), .we(audio_we), .waddr(audio_waddr), .wdata(audio_wdata),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

    sequencer u_seq (
        .ck(ck), .rst_n(rst_n),
        .start(run_req || cap_start),
        .frame(host_mode ? host_frame : frame_counter),
        .coef_addr(coef_raddr), .coef_data(coef_rdata),
        .audio_addr(audio_raddr), .audio_data(audio_rdata),
        .left(res_left), .right(res_right),
        .done(done), .busy(busy), .error(error), .error_clr(ctl_wr)
    );

endmodule

`default_nettype wire

// ==== sim/tb_audio_engine.sv ====
// Testbench for the audio peripheral. Drives the iomem bus and both I2S
// input lines, decodes sd_out, and checks results against a behavioral
// model of the multiply-accumulate program. Built from vlog.f at the root.
`timescale 1ns/10ps
`default_nettype none

module tb_audio_engine ();

    localparam logic [31:0] BASE       = 32'h0000_6000;
    localparam logic [31:0] A_COEF     = BASE + 32'h000;
    localparam logic [31:0] A_RESULT   = BASE + 32'h100;
    localparam logic [31:0] A_STATUS   = BASE + 32'h200;
    localparam logic [31:0] A_COUNTER  = BASE + 32'h204;
    localparam logic [31:0] A_RUN      = BASE + 32'h300;
    localparam logic [31:0] A_AUDIO    = BASE + 32'h400;
    localparam logic [31:0] A_UNMAPPED = BASE + 32'h800;
    localparam logic [7:0]  HOST_FRAME = 8'd3;

    logic        ck, rst_n, iomem_valid, iomem_ready;
    logic [3:0]  iomem_wstrb;
    logic [31:0] iomem_addr, iomem_wdata, iomem_rdata;
    logic        sck, ws, sd_out, sd_in0, sd_in1;

    // Model copies of what was written into the DUT RAMs
    logic [15:0] audio_m [4][256];
    logic [31:0] coef_m [16];
    logic [31:0] smp0 [8];
    logic [31:0] smp1 [8];
    logic [31:0] rx_words [$];
    logic [15:0] lfsr;
    int          errors, checks, test_num, tests_failed, test_start_errors;

    logic        mon_sck = 1'b0;
    logic        mon_ws = 1'b0;
    logic [31:0] mon_word = '0;
    int          mon_cnt = 100;

    audio_engine #(.BASE_ADDR(BASE), .DIVIDER(6)) i_dut (.*);

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    // Ready is a single clock pulse, rdata is zero outside it
    assert property (@(posedge ck) disable iff (!rst_n) iomem_ready |=> !iomem_ready)
        else begin
            errors++;
            $display("iomem_ready was held high for more than one cycle");
        end

    assert property (@(posedge ck) disable iff (!rst_n) !iomem_ready |-> iomem_rdata == '0)
        else begin
            errors++;
            $display("FAIL iomem_rdata: got 0x%08h, expected 0x00000000", iomem_rdata);
        end

    // Decodes sd_out into one {left, right} word per frame, sampled on sck rise
    always @(negedge ck) begin
        if (!mon_sck && sck) begin
            if (mon_ws && !ws) begin
                mon_cnt = 0;
            end
            mon_word = {mon_word[30:0], sd_out};
            mon_cnt++;
            if (mon_cnt == 32) begin
                rx_words.push_back(mon_word);
            end
            mon_ws = ws;
        end
        mon_sck = sck;
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit taken
    function automatic logic [31:0] next_rand(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Sum of sample times Q1.15 gain over 8 taps, shifted by 15 and saturated
    function automatic logic [15:0] model_output(input int sel, input logic [7:0] fr);
        longint      acc;
        longint      sum;
        logic [31:0] c;
        logic [7:0]  tap_fr;
        acc = 0;
        for (int t = 0; t < 8; t++) begin
            c      = coef_m[sel * 8 + t];
            tap_fr = fr - c[23:16];
            acc += longint'($signed(audio_m[c[25:24]][tap_fr])) * longint'($signed(c[15:0]));
        end
        sum = acc >>> 15;
        if (sum > 32767) begin
            return 16'h7fff;
        end
        if (sum < -32768) begin
            return 16'h8000;
        end
        return sum[15:0];
    endfunction

    task automatic access_bus(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge ck);
        iomem_valid = 1'b1;
        iomem_addr  = addr;
        iomem_wdata = data;
        iomem_wstrb = strb;
        @(negedge ck);
        while (!iomem_ready && n < 16) begin
            @(negedge ck);
            n++;
        end
        rdata = iomem_rdata;
        if (!iomem_ready) begin
            errors++;
            $display("Bus access to 0x%08h was never acknowledged", addr);
        end
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        access_bus(addr, data, 4'hf, unused);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        access_bus(addr, 32'h0, 4'h0, data);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            end
    endtask

    task automatic poll_done();
        logic [31:0] st;
        int          n;
        st = '0;
        n  = 0;
        while (!st[0] && n < 100) begin
            read_reg(A_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            errors++;
            $display("Sequencer never reported done");
        end
    endtask

    task automatic wait_frame_start();
        logic prev;
        int   n;
        n    = 0;
        prev = ws;
        @(negedge ck);
        while (!(prev && !ws) && n < 800) begin
            prev = ws;
            @(negedge ck);
            n++;
        end
        if (!(prev && !ws)) begin
            errors++;
            $display("No I2S frame start was seen on ws");
        end
    endtask

    task automatic wait_sck_fall();
        logic prev;
        int   n;
        n    = 0;
        prev = sck;
        @(negedge ck);
        while (!(prev && !sck) && n < 40) begin
            prev = sck;
            @(negedge ck);
            n++;
        end
        if (!(prev && !sck)) begin
            errors++;
            $display("sck stopped toggling");
        end
    endtask

    // One frame on both lines, {left, right} MSB first, changing after sck falls
    task automatic send_frame(input logic [31:0] w0, input logic [31:0] w1, output int mark);
        wait_frame_start();
        mark = rx_words.size();
        for (int k = 0; k < 32; k++) begin
            if (k > 0) begin
                wait_sck_fall();
            end
            sd_in0 = w0[31 - k];
            sd_in1 = w1[31 - k];
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic [31:0] rd, c0, c1, l0, l1, r0, r1, st0, st1, w;
        logic [15:0] s, el, er;
        logic [7:0]  fr;
        int          mark [8];
        int          n;
        lfsr = 16'd16;
        errors = 0;
        checks = 0;
        test_num = 0;
        tests_failed = 0;
        test_start_errors = 0;
        rst_n = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
        iomem_addr = '0;
        iomem_wdata = '0;
        sd_in0 = 1'b0;
        sd_in1 = 1'b0;
        repeat (5) @(negedge ck);
        rst_n = 1'b1;

        // Must finish before the first frame start triggers a capture run
        for (int i = 0; i < 8; i++) begin
            @(negedge ck);
            expect_value("iomem_ready", 32'(iomem_ready), 32'h0);
            expect_value("sd_out", 32'(sd_out), 32'h0);
        end
        read_reg(A_STATUS, rd);
        expect_value("status", rd, 32'h0);
        // Valid held across the ready cycle still gets a single pulse
        @(negedge ck);
        iomem_valid = 1'b1;
        iomem_addr  = A_STATUS;
        iomem_wstrb = 4'h0;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            @(negedge ck);
            if (iomem_ready) begin
                n++;
            end
        end
        iomem_valid = 1'b0;
        expect_value("iomem_ready pulses", 32'(n), 32'h1);
        end_test("reset state");

        write_reg(A_STATUS, {23'h0, HOST_FRAME, 1'b1});
        for (int f = 0; f < 8; f++) begin
            fr = HOST_FRAME - 8'(f);
            for (int ch = 0; ch < 4; ch++) begin
                s = 16'(next_rand(16));
                audio_m[ch][fr] = s;
                write_reg(A_AUDIO + {22'h0, fr, 2'b00}, {14'h0, 2'(ch), s});
            end
        end
        // Delay equals tap number, so taps 4 to 7 wrap below frame 0
        for (int k = 0; k < 16; k++) begin
            coef_m[k] = {6'h0, 2'(next_rand(2)), 8'(k % 8), 16'(next_rand(16))};
            write_reg(A_COEF + 32'(k * 4), coef_m[k]);
        end
        write_reg(A_RUN, 32'h1);
        poll_done();
        read_reg(A_RESULT, rd);
        expect_value("result left", rd, {16'h0, model_output(0, HOST_FRAME)});
        read_reg(A_RESULT + 32'h4, rd);
        expect_value("result right", rd, {16'h0, model_output(1, HOST_FRAME)});
        end_test("host multiply-accumulate");

        write_reg(A_AUDIO + {22'h0, HOST_FRAME, 2'b00}, {14'h0, 2'd0, 16'h7fff});
        write_reg(A_AUDIO + {22'h0, HOST_FRAME, 2'b00}, {14'h0, 2'd1, 16'h8000});
        for (int k = 0; k < 16; k++) begin
            coef_m[k] = {6'h0, (k < 8) ? 2'd0 : 2'd1, 8'h0, 16'h7fff};
            write_reg(A_COEF + 32'(k * 4), coef_m[k]);
        end
        write_reg(A_RUN, 32'h1);
        poll_done();
        read_reg(A_RESULT, rd);
        expect_value("result left", rd, 32'h0000_7fff);
        read_reg(A_RESULT + 32'h4, rd);
        expect_value("result right", rd, 32'h0000_8000);
        end_test("saturation");

        write_reg(A_STATUS, {23'h0, HOST_FRAME, 1'b1});
        write_reg(A_RUN, 32'h1);
        write_reg(A_RUN, 32'h1);
        read_reg(A_STATUS, rd);
        expect_value("status error", 32'(rd[1]), 32'h1);
        poll_done();
        write_reg(A_STATUS, {23'h0, HOST_FRAME, 1'b1});
        read_reg(A_STATUS, rd);
        expect_value("status error", 32'(rd[1]), 32'h0);
        end_test("start while busy");

        // Half gain on tap 0, channel 0 to left and channel 3 to right
        for (int k = 0; k < 16; k++) begin
            coef_m[k] = {6'h0, (k < 8) ? 2'd0 : 2'd3, 8'h0, (k % 8 == 0) ? 16'h4000 : 16'h0};
            write_reg(A_COEF + 32'(k * 4), coef_m[k]);
        end
        write_reg(A_STATUS, 32'h0);
        read_reg(A_COUNTER, c0);
        for (int i = 0; i < 5; i++) begin
            smp0[i] = next_rand(32);
            smp1[i] = next_rand(32);
            send_frame(smp0[i], smp1[i], mark[i]);
        end
        read_reg(A_COUNTER, c1);
        expect_value("frame counter", {24'h0, c1[7:0] - c0[7:0]}, 32'h5);
        n = 0;
        while (rx_words.size() <= mark[4] && n < 400) begin
            @(negedge ck);
            n++;
        end
        sd_in0 = 1'b0;
        sd_in1 = 1'b0;
        if (rx_words.size() <= mark[4]) begin
            errors++;
            $display("No output word was decoded from sd_out in the last frame");
        end else begin
            for (int i = 2; i < 5; i++) begin
                w  = rx_words[mark[i]];
                el = $signed(smp0[i - 2][31:16]) >>> 1;
                er = $signed(smp1[i - 2][15:0]) >>> 1;
                expect_value("sd_out left", {16'h0, w[31:16]}, {16'h0, el});
                expect_value("sd_out right", {16'h0, w[15:0]}, {16'h0, er});
            end
        end
        end_test("capture and loopback");

        // Host mode stops capture runs so the results hold still
        write_reg(A_STATUS, {23'h0, HOST_FRAME, 1'b1});
        rd = 32'h4;
        n = 0;
        while (rd[2] && n < 100) begin
            read_reg(A_STATUS, rd);
            n++;
        end
        if (rd[2]) begin
            errors++;
            $display("Sequencer stayed busy");
        end
        read_reg(A_RESULT, l0);
        read_reg(A_RESULT + 32'h4, r0);
        read_reg(A_STATUS, st0);
        write_reg(A_UNMAPPED, 32'hffff_ffff);
        read_reg(A_UNMAPPED, rd);
        expect_value("iomem_rdata unmapped", rd, 32'h0);
        read_reg(A_RESULT, l1);
        read_reg(A_RESULT + 32'h4, r1);
        read_reg(A_STATUS, st1);
        expect_value("result left", l1, l0);
        expect_value("result right", r1, r0);
        expect_value("status", st1, st0);
        end_test("unmapped access");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/audio_pkg.sv
source/bus_pkg.sv
source/i2s_if.sv
source/i2s_clock.sv
source/i2s_rx.sv
source/i2s_tx.sv
source/dpram.sv
source/sequencer.sv
source/audio_engine.sv
sim/tb_audio_engine.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_audio_engine &&
./obj_dir/Vtb_audio_engine | tee /dev/stderr | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
